/* gb_map_pkg.sv */
`default_nettype none

package gb_map_pkg;

	// -------------------------------------------------------------------
	// io register addresses
	// -------------------------------------------------------------------
	localparam logic [15:0] addr_joyp = 16'hff00; // P1 joypad select
	localparam logic [15:0] addr_div  = 16'hff04; // timer block starts here
	localparam logic [15:0] addr_tima = 16'hff05;
	localparam logic [15:0] addr_tma  = 16'hff06;
	localparam logic [15:0] addr_tac  = 16'hff07;
	localparam logic [15:0] addr_if   = 16'hff0f; // interrupt flags
	localparam logic [15:0] addr_key1 = 16'hff4d; // colour speed switch
	localparam logic [15:0] addr_svbk = 16'hff70; // colour wram bank
	localparam logic [15:0] addr_ie   = 16'hffff; // interrupt enable

	// ram windows
	localparam logic [1:0] iram_base_bits = 2'b11;     // c000 and up
	localparam logic [8:0] zpram_page     = 9'h1ff;    // ff80 - fffe

	// interrupt vectors, bit 0 first
	localparam logic [7:0] vec_vblank = 8'h40;
	localparam logic [7:0] vec_lcd    = 8'h48;
	localparam logic [7:0] vec_timer  = 8'h50;
	localparam logic [7:0] vec_serial = 8'h58;
	localparam logic [7:0] vec_joypad = 8'h60;
	localparam logic [7:0] vec_none   = 8'h55; // nothing pending

	localparam logic [7:0] open_bus  = 8'hff;
	localparam int         irq_count = 5;

	// divider bit per TAC rate code 00..11
	localparam int tac_tap_bits [0:3] = '{9, 3, 5, 7};

	localparam logic [2:0] svbk_reset = 3'd1;
	localparam logic [1:0] p54_reset  = 2'b11; // both groups deselected

endpackage

`default_nettype wire

/* gb_types_pkg.sv */
`default_nettype none

package gb_types_pkg;

	// -------------------------------------------------------------------
	// plain widths
	// -------------------------------------------------------------------
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] cpu_addr_t;
	typedef logic [gb_map_pkg::irq_count-1:0] irq_mask_t; // one bit per source
	typedef logic [2:0]  wram_bank_t;
	typedef logic [14:0] iram_addr_t;  // 32k physical
	typedef logic [15:0] div_count_t;  // DIV is the upper byte

	// -------------------------------------------------------------------
	// bus and selects
	// -------------------------------------------------------------------
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     wdata;
		logic      rd;
		logic      wr;     // commits on the rising edge
	} cpu_bus_t;

	typedef struct packed {
		logic joyp;
		logic timer;   // ff04 - ff07
		logic intf;
		logic ie;
		logic key1;
		logic svbk;
		logic iram;    // c000 - fdff incl. echo
		logic zpram;   // ff80 - fffe
	} gb_sel_t;

	// KEY1 speed switch
	typedef enum logic [1:0] {
		spd_normal,
		spd_normal_armed,
		spd_double,
		spd_double_armed
	} speed_state_t;

endpackage

`default_nettype wire

/* gb_bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module gb_bus_decode (
	input  wire gb_types_pkg::cpu_bus_t bus,
	input  wire                         irq_ack,
	input  wire gb_types_pkg::byte_t    irq_vec,
	input  wire gb_types_pkg::byte_t    timer_rdata,
	input  wire gb_types_pkg::byte_t    joy_rdata,
	input  wire gb_types_pkg::byte_t    key1_rdata,
	input  wire gb_types_pkg::byte_t    svbk_rdata,
	input  wire gb_types_pkg::byte_t    ram_rdata,
	input  wire gb_types_pkg::byte_t    if_rdata,
	input  wire gb_types_pkg::byte_t    ie_rdata,
	output gb_types_pkg::gb_sel_t       sel,
	output gb_types_pkg::byte_t         rdata
);

	// -------------------------------------------------------------------
	// address decode
	// -------------------------------------------------------------------
	always_comb begin
		sel.joyp  = (bus.addr == gb_map_pkg::addr_joyp);
		sel.timer = (bus.addr[15:2] == gb_map_pkg::addr_div[15:2]); // ff04..ff07
		sel.intf  = (bus.addr == gb_map_pkg::addr_if);
		sel.ie    = (bus.addr == gb_map_pkg::addr_ie);
		sel.key1  = (bus.addr == gb_map_pkg::addr_key1);
		sel.svbk  = (bus.addr == gb_map_pkg::addr_svbk);
		// c000 up to fdff, fe00 and above is io space
		sel.iram  = (bus.addr[15:14] == gb_map_pkg::iram_base_bits) &&
			(bus.addr[15:9] != 7'h7f);
		// ffff is IE and not zero page
		sel.zpram = (bus.addr[15:7] == gb_map_pkg::zpram_page) &&
			(bus.addr != gb_map_pkg::addr_ie);
	end

	// -------------------------------------------------------------------
	// cpu read data
	// -------------------------------------------------------------------
	// selects are one-hot, ack cycle wins over everything
	always_comb begin
		if (irq_ack)
			rdata = irq_vec;          // vector fetch
		else if (sel.intf)
			rdata = if_rdata;
		else if (sel.ie)
			rdata = ie_rdata;
		else if (sel.joyp)
			rdata = joy_rdata;
		else if (sel.timer)
			rdata = timer_rdata;
		else if (sel.key1)
			rdata = key1_rdata;
		else if (sel.svbk)
			rdata = svbk_rdata;
		else if (sel.iram || sel.zpram)
			rdata = ram_rdata;        // registered, valid a cycle later
		else
			rdata = gb_map_pkg::open_bus;
	end

endmodule

`default_nettype wire

/* gb_irq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module gb_irq_ctrl (
	input  wire                         clk_cpu,
	input  wire                         reset,
	input  wire gb_types_pkg::cpu_bus_t bus,
	input  wire gb_types_pkg::gb_sel_t  sel,
	input  wire                         irq_ack,
	input  wire                         timer_irq,
	input  wire                         joy_irq,
	output logic                        irq_n,
	output gb_types_pkg::byte_t         irq_vec,
	output gb_types_pkg::byte_t         if_rdata,
	output gb_types_pkg::byte_t         ie_rdata
);

	gb_types_pkg::irq_mask_t if_r;
	gb_types_pkg::irq_mask_t ie_r;
	gb_types_pkg::irq_mask_t pending;
	gb_types_pkg::irq_mask_t set_mask;
	gb_types_pkg::irq_mask_t ack_clear;
	gb_types_pkg::irq_mask_t if_next;
	logic                    ack_d;  // irq_ack one cycle back

	assign pending  = if_r & ie_r;
	assign irq_n    = ~|pending;              // low while anything enabled is set
	assign set_mask = {joy_irq, 1'b0, timer_irq, 2'b00}; // bits 4 and 2, serial only by write

	// lowest set bit of pending, cleared when ack drops
	assign ack_clear = (ack_d && !irq_ack) ? (pending & (~pending + 1'b1)) : '0;
	assign if_next   = (if_r | set_mask) & ~ack_clear;

	// priority vector, bit 0 highest
	always_comb begin
		casez (pending)
			5'b????1: irq_vec = gb_map_pkg::vec_vblank;
			5'b???10: irq_vec = gb_map_pkg::vec_lcd;
			5'b??100: irq_vec = gb_map_pkg::vec_timer;
			5'b?1000: irq_vec = gb_map_pkg::vec_serial;
			5'b10000: irq_vec = gb_map_pkg::vec_joypad;
			default:  irq_vec = gb_map_pkg::vec_none;
		endcase
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r  <= '0;
			ie_r  <= '0;
			ack_d <= 1'b0;
		end else begin
			ack_d <= irq_ack;
			if_r  <= if_next;
			if (sel.intf && bus.wr)
				if_r <= bus.wdata[gb_map_pkg::irq_count-1:0]; // cpu write wins
			if (sel.ie && bus.wr)
				ie_r <= bus.wdata[gb_map_pkg::irq_count-1:0];
		end
	end

	assign if_rdata = {3'b111, if_r};  // unused bits read high
	assign ie_rdata = {3'b000, ie_r};

endmodule

`default_nettype wire

/* gb_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module gb_timer (
	input  wire                         clk_cpu,
	input  wire                         reset,
	input  wire gb_types_pkg::cpu_bus_t bus,
	input  wire gb_types_pkg::gb_sel_t  sel,
	output logic                        timer_irq,
	output gb_types_pkg::byte_t         timer_rdata
);

	gb_types_pkg::div_count_t divider_count;  // free running
	gb_types_pkg::byte_t      tima;
	gb_types_pkg::byte_t      tma;            // reload value
	logic [2:0]               tac;            // enable + rate
	logic                     tap_bit;
	logic                     tap_en;
	logic                     tap_d;
	logic                     tima_tick;

	// -------------------------------------------------------------------
	// rate select
	// -------------------------------------------------------------------
	always_comb begin
		case (tac[1:0])
			2'd0:    tap_bit = divider_count[gb_map_pkg::tac_tap_bits[0]]; // 4096 Hz
			2'd1:    tap_bit = divider_count[gb_map_pkg::tac_tap_bits[1]];
			2'd2:    tap_bit = divider_count[gb_map_pkg::tac_tap_bits[2]];
			default: tap_bit = divider_count[gb_map_pkg::tac_tap_bits[3]];
		endcase
	end

	assign tap_en    = tap_bit && tac[2];
	assign tima_tick = tap_d && !tap_en;  // falling edge of gated tap

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			divider_count <= '0;
			tima          <= '0;
			tma           <= '0;
			tac           <= '0;
			tap_d         <= 1'b0;
			timer_irq     <= 1'b0;
		end else begin
			divider_count <= divider_count + 1'b1;
			tap_d         <= tap_en;
			timer_irq     <= 1'b0;
			if (tima_tick) begin
				if (tima == 8'hff) begin
					tima      <= tma;   // overflow reload
					timer_irq <= 1'b1;
				end else
					tima <= tima + 1'b1;
			end
			if (sel.timer && bus.wr) begin
				case (bus.addr[1:0])
					2'd0:    divider_count <= '0;   // any write clears DIV
					2'd1:    tima <= bus.wdata;
					2'd2:    tma <= bus.wdata;
					default: tac <= bus.wdata[2:0];
				endcase
			end
		end
	end

	// register reads
	always_comb begin
		case (bus.addr[1:0])
			2'd0:    timer_rdata = divider_count[15:8];
			2'd1:    timer_rdata = tima;
			2'd2:    timer_rdata = tma;
			default: timer_rdata = {5'b11111, tac};
		endcase
	end

endmodule

`default_nettype wire

/* gb_speed_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module gb_speed_fsm (
	input  wire                         clk_cpu,
	input  wire                         reset,
	input  wire gb_types_pkg::cpu_bus_t bus,
	input  wire gb_types_pkg::gb_sel_t  sel,
	input  wire                         is_gbc,
	input  wire                         stop,
	output logic                        speed,
	output gb_types_pkg::byte_t         key1_rdata
);

	gb_types_pkg::speed_state_t state;
	gb_types_pkg::speed_state_t state_next;
	logic                       armed;

	assign speed = (state == gb_types_pkg::spd_double) ||
		(state == gb_types_pkg::spd_double_armed);
	assign armed = (state == gb_types_pkg::spd_normal_armed) ||
		(state == gb_types_pkg::spd_double_armed);

	always_comb begin
		state_next = state;
		if (stop && armed)  // STOP executes the switch and disarms
			state_next = speed ? gb_types_pkg::spd_normal : gb_types_pkg::spd_double;
		else if (sel.key1 && bus.wr && is_gbc) begin
			if (speed)
				state_next = bus.wdata[0] ? gb_types_pkg::spd_double_armed
					: gb_types_pkg::spd_double;
			else
				state_next = bus.wdata[0] ? gb_types_pkg::spd_normal_armed
					: gb_types_pkg::spd_normal;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (reset)
			state <= gb_types_pkg::spd_normal;
		else
			state <= state_next;
	end

	assign key1_rdata = {speed, 6'h3f, armed};

endmodule

`default_nettype wire

/* gb_joypad.sv */
`timescale 1ns/1ps
`default_nettype none

module gb_joypad (
	input  wire                         clk_cpu,
	input  wire                         reset,
	input  wire gb_types_pkg::cpu_bus_t bus,
	input  wire gb_types_pkg::gb_sel_t  sel,
	input  wire gb_types_pkg::byte_t    joystick,  // active high buttons
	output logic [5:0]                  joy_p54,
	output logic                        joy_irq,
	output gb_types_pkg::byte_t         joy_rdata
);

	logic [1:0] p54;       // P15 P14 select, low selects
	logic [3:0] joy_dir;   // down up left right
	logic [3:0] joy_btn;   // start select b a
	logic [7:0] lines_d;
	logic [7:0] lines_d2;

	assign joy_dir = ~{joystick[3], joystick[2], joystick[1], joystick[0]} | {4{p54[0]}};
	assign joy_btn = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};
	assign joy_p54 = {p54, joy_dir & joy_btn};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54      <= gb_map_pkg::p54_reset;
			lines_d  <= 8'hff;  // released
			lines_d2 <= 8'hff;
		end else begin
			if (sel.joyp && bus.wr)
				p54 <= bus.wdata[5:4];
			lines_d  <= {joy_dir, joy_btn};
			lines_d2 <= lines_d;
		end
	end

	assign joy_irq   = |(~lines_d & lines_d2);  // any line fell
	assign joy_rdata = {2'b11, joy_p54};

endmodule

`default_nettype wire

/* gb_work_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module gb_work_ram (
	input  wire                         clk_cpu,
	input  wire                         reset,
	input  wire gb_types_pkg::cpu_bus_t bus,
	input  wire gb_types_pkg::gb_sel_t  sel,
	input  wire                         is_gbc,
	output gb_types_pkg::byte_t         ram_rdata,
	output gb_types_pkg::byte_t         svbk_rdata
);

	gb_types_pkg::wram_bank_t bank;      // 1..7, only colour mode moves it
	gb_types_pkg::iram_addr_t iram_addr;
	gb_types_pkg::byte_t      iram [0:32767];
	gb_types_pkg::byte_t      zpram [0:127];

	// -------------------------------------------------------------------
	// SVBK
	// -------------------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset)
			bank <= gb_map_pkg::svbk_reset;
		else if (sel.svbk && bus.wr && is_gbc)
			bank <= (bus.wdata[2:0] == 3'd0) ? 3'd1 : bus.wdata[2:0]; // 0 maps to 1
	end

	assign svbk_rdata = {5'h1f, bank};

	// c000 fixed bank 0, d000 switchable
	assign iram_addr = bus.addr[12] ? {bank, bus.addr[11:0]} : {3'd0, bus.addr[11:0]};

	// -------------------------------------------------------------------
	// arrays with a shared registered read
	// -------------------------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (sel.iram && bus.wr)
			iram[iram_addr] <= bus.wdata;
		if (sel.zpram && bus.wr)
			zpram[bus.addr[6:0]] <= bus.wdata;
		if (bus.rd && (sel.iram || sel.zpram))
			ram_rdata <= sel.zpram ? zpram[bus.addr[6:0]] : iram[iram_addr];
	end

endmodule

`default_nettype wire

/* gb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module gb_core (
	input  wire                         clk_cpu,
	input  wire                         reset,
	input  wire gb_types_pkg::cpu_bus_t bus,
	input  wire                         irq_ack,
	input  wire                         stop,
	input  wire                         is_gbc,
	input  wire gb_types_pkg::byte_t    joystick,
	output gb_types_pkg::byte_t         rdata,
	output logic                        irq_n,
	output logic                        speed,
	output logic [5:0]                  joy_p54
);

	gb_types_pkg::gb_sel_t sel;
	gb_types_pkg::byte_t   irq_vec;
	gb_types_pkg::byte_t   if_rdata;
	gb_types_pkg::byte_t   ie_rdata;
	gb_types_pkg::byte_t   timer_rdata;
	gb_types_pkg::byte_t   joy_rdata;
	gb_types_pkg::byte_t   key1_rdata;
	gb_types_pkg::byte_t   svbk_rdata;
	gb_types_pkg::byte_t   ram_rdata;
	logic                  timer_irq;   // one cycle pulses
	logic                  joy_irq;

	gb_bus_decode decode0 (
		.bus(bus), .irq_ack(irq_ack), .irq_vec(irq_vec),
		.timer_rdata(timer_rdata), .joy_rdata(joy_rdata), .key1_rdata(key1_rdata),
		.svbk_rdata(svbk_rdata), .ram_rdata(ram_rdata), .if_rdata(if_rdata),
		.ie_rdata(ie_rdata), .sel(sel), .rdata(rdata)
	);

	gb_irq_ctrl irq0 (
		.clk_cpu(clk_cpu), .reset(reset), .bus(bus), .sel(sel), .irq_ack(irq_ack),
		.timer_irq(timer_irq), .joy_irq(joy_irq), .irq_n(irq_n), .irq_vec(irq_vec),
		.if_rdata(if_rdata), .ie_rdata(ie_rdata)
	);

	gb_timer timer0 (
		.clk_cpu(clk_cpu), .reset(reset), .bus(bus), .sel(sel),
		.timer_irq(timer_irq), .timer_rdata(timer_rdata)
	);

	gb_speed_fsm speed0 (
		.clk_cpu(clk_cpu), .reset(reset), .bus(bus), .sel(sel), .is_gbc(is_gbc),
		.stop(stop), .speed(speed), .key1_rdata(key1_rdata)
	);

	gb_joypad joy0 (
		.clk_cpu(clk_cpu), .reset(reset), .bus(bus), .sel(sel), .joystick(joystick),
		.joy_p54(joy_p54), .joy_irq(joy_irq), .joy_rdata(joy_rdata)
	);

	gb_work_ram wram0 (
		.clk_cpu(clk_cpu), .reset(reset), .bus(bus), .sel(sel), .is_gbc(is_gbc),
		.ram_rdata(ram_rdata), .svbk_rdata(svbk_rdata)
	);

endmodule

`default_nettype wire

/* tb_gb_tasks.svh */
`ifndef tb_gb_tasks_svh
`define tb_gb_tasks_svh

// -------------------------------------------------------------------
// stimulus helpers
// -------------------------------------------------------------------
// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic gb_types_pkg::byte_t rand_byte();
	gb_types_pkg::byte_t b;
	logic                fb;
	b = '0;
	for (int i = 0; i < 8; i++) begin
		fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		b          = {b[6:0], fb};
	end
	return b;
endfunction

function automatic gb_types_pkg::cpu_bus_t make_bus(input gb_types_pkg::cpu_addr_t addr,
	input gb_types_pkg::byte_t wdata, input logic rd, input logic wr);
	gb_types_pkg::cpu_bus_t b;
	b.addr  = addr;
	b.wdata = wdata;
	b.rd    = rd;
	b.wr    = wr;
	return b;
endfunction

// vectors are 8 bytes apart from 40, lowest flag wins
function automatic gb_types_pkg::byte_t expected_vector(input gb_types_pkg::irq_mask_t mask);
	gb_types_pkg::byte_t vec;
	vec = 8'h55;
	for (int i = gb_map_pkg::irq_count - 1; i >= 0; i--)
		if (mask[i])
			vec = 8'h40 + 8'(i * 8);
	return vec;
endfunction

task automatic bus_write(input gb_types_pkg::cpu_addr_t addr, input gb_types_pkg::byte_t data);
	@(posedge clk_cpu);
	bus <= make_bus(addr, data, 1'b0, 1'b1);
	@(posedge clk_cpu);                          // write lands here
	bus <= make_bus(16'h0000, 8'h00, 1'b0, 1'b0);
endtask

// register read, same cycle
task automatic read_reg(input gb_types_pkg::cpu_addr_t addr, output gb_types_pkg::byte_t data);
	@(posedge clk_cpu);
	bus <= make_bus(addr, 8'h00, 1'b1, 1'b0);
	@(negedge clk_cpu);
	data = rdata;
endtask

// ram read, address held two cycles
task automatic read_ram(input gb_types_pkg::cpu_addr_t addr, output gb_types_pkg::byte_t data);
	@(posedge clk_cpu);
	bus <= make_bus(addr, 8'h00, 1'b1, 1'b0);
	@(posedge clk_cpu);
	@(negedge clk_cpu);
	data = rdata;
endtask

task automatic pulse_stop();
	@(posedge clk_cpu);
	stop <= 1'b1;
	@(posedge clk_cpu);                          // switch edge
	stop <= 1'b0;
endtask

// wait for one register bit, bounded
task automatic wait_reg_bit(input gb_types_pkg::cpu_addr_t addr, input int bit_no,
	input int limit, input string name);
	gb_types_pkg::byte_t rd_val;
	int                  waited;
	rd_val = 8'h00;
	waited = 0;
	while (!rd_val[bit_no] && waited < limit) begin
		read_reg(addr, rd_val);
		waited++;
	end
	if (!rd_val[bit_no]) begin
		timeout_errors++;
		$display("timeout in %s: bit %0d at %04h never became set", name, bit_no, addr);
	end
endtask

// -------------------------------------------------------------------
// compare tasks
// -------------------------------------------------------------------
task automatic check_byte(input string name, input gb_types_pkg::byte_t expected,
	input gb_types_pkg::byte_t actual);
	check_count++;
	if (actual !== expected) begin
		value_errors++;
		$display("error %s: expected %02h, actual %02h", name, expected, actual);
	end
endtask

task automatic check_mask(input string name, input gb_types_pkg::irq_mask_t expected,
	input gb_types_pkg::irq_mask_t actual);
	check_count++;
	if (actual !== expected) begin
		value_errors++;
		$display("error %s: expected %02h, actual %02h", name, expected, actual);
	end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
	check_count++;
	if (actual !== expected) begin
		value_errors++;
		$display("error %s: expected %0b, actual %0b", name, expected, actual);
	end
endtask

// -------------------------------------------------------------------
// tests
// -------------------------------------------------------------------
task automatic check_reset_values();
	gb_types_pkg::byte_t rd_val;
	@(negedge clk_cpu);
	check_bit("reset irq_n", 1'b1, irq_n);
	check_bit("reset speed", 1'b0, speed);
	check_byte("reset joy_p54", 8'h3f, {2'b00, joy_p54});
	read_reg(gb_map_pkg::addr_if, rd_val);
	check_byte("reset IF", 8'he0, rd_val);   // top bits read high
	read_reg(gb_map_pkg::addr_ie, rd_val);
	check_byte("reset IE", 8'h00, rd_val);
	read_reg(gb_map_pkg::addr_svbk, rd_val);
	check_byte("reset SVBK", 8'hf9, rd_val);
	read_reg(gb_map_pkg::addr_tima, rd_val);
	check_byte("reset TIMA", 8'h00, rd_val);
endtask

task automatic test_ram_banking();
	gb_types_pkg::byte_t data [0:15];
	gb_types_pkg::byte_t rd_val;
	@(posedge clk_cpu);
	is_gbc <= 1'b1;
	for (int i = 0; i < 16; i++)
		data[i] = rand_byte();
	for (int i = 0; i < 4; i++) begin
		bus_write(16'hc000 + 16'(i * 'h111), data[i]);      // fixed bank 0
		bus_write(16'hff80 + 16'(i * 'h1f), data[12 + i]);  // zero page
	end
	bus_write(gb_map_pkg::addr_svbk, 8'h02);
	for (int i = 0; i < 4; i++)
		bus_write(16'hd000 + 16'(i * 'h123), data[4 + i]);
	bus_write(gb_map_pkg::addr_svbk, 8'h03);
	for (int i = 0; i < 4; i++)
		bus_write(16'hd000 + 16'(i * 'h123), data[8 + i]);  // same offsets, bank 3
	for (int i = 0; i < 4; i++) begin
		read_ram(16'hd000 + 16'(i * 'h123), rd_val);
		check_byte("ram bank 3", data[8 + i], rd_val);
	end
	bus_write(gb_map_pkg::addr_svbk, 8'h02);
	for (int i = 0; i < 4; i++) begin
		read_ram(16'hd000 + 16'(i * 'h123), rd_val);
		check_byte("ram bank 2", data[4 + i], rd_val);
		read_ram(16'hc000 + 16'(i * 'h111), rd_val);
		check_byte("ram bank 0", data[i], rd_val);
		read_ram(16'hff80 + 16'(i * 'h1f), rd_val);
		check_byte("zero page ram", data[12 + i], rd_val);
	end
	bus_write(gb_map_pkg::addr_svbk, 8'h00);   // 0 turns into 1
	read_reg(gb_map_pkg::addr_svbk, rd_val);
	check_byte("svbk zero write", 8'hf9, rd_val);
	@(posedge clk_cpu);
	is_gbc <= 1'b0;
	bus_write(gb_map_pkg::addr_svbk, 8'h05);
	read_reg(gb_map_pkg::addr_svbk, rd_val);
	check_byte("svbk mono write", 8'hf9, rd_val);
endtask

task automatic test_irq_priority();
	gb_types_pkg::irq_mask_t remaining;
	gb_types_pkg::byte_t     rd_val;
	int                      rounds;
	rd_val    = rand_byte();
	remaining = rd_val[4:0];
	if (remaining == '0)
		remaining = 5'h15;   // need something pending
	bus_write(gb_map_pkg::addr_ie, 8'h1f);
	bus_write(gb_map_pkg::addr_if, {3'b000, remaining});
	read_reg(gb_map_pkg::addr_if, rd_val);
	check_mask("irq flags written", remaining, rd_val[4:0]);
	check_bit("irq_n pending", 1'b0, irq_n);
	rounds = 0;
	while (remaining != '0 && rounds < gb_map_pkg::irq_count) begin
		@(posedge clk_cpu);
		irq_ack <= 1'b1;
		@(negedge clk_cpu);
		check_byte("irq vector", expected_vector(remaining), rdata);
		@(posedge clk_cpu);
		irq_ack <= 1'b0;
		remaining = remaining & (remaining - 5'd1);   // lowest flag goes
		read_reg(gb_map_pkg::addr_if, rd_val);         // clear edge is here
		check_mask("irq flags after ack", remaining, rd_val[4:0]);
		rounds++;
	end
	@(posedge clk_cpu);
	irq_ack <= 1'b1;
	@(negedge clk_cpu);
	check_byte("irq vector idle", 8'h55, rdata);
	check_bit("irq_n idle", 1'b1, irq_n);
	@(posedge clk_cpu);
	irq_ack <= 1'b0;
endtask

task automatic test_timer();
	gb_types_pkg::byte_t tma_val;
	gb_types_pkg::byte_t rd_val;
	gb_types_pkg::byte_t diff;
	int                  timeouts_before;
	tma_val         = rand_byte();
	timeouts_before = timeout_errors;
	bus_write(gb_map_pkg::addr_tma, tma_val);
	bus_write(gb_map_pkg::addr_tima, 8'hfe);
	bus_write(gb_map_pkg::addr_if, 8'h00);
	bus_write(gb_map_pkg::addr_tac, 8'h05);   // enable, divider bit 3
	wait_reg_bit(gb_map_pkg::addr_if, 2, 200, "timer overflow");
	if (timeout_errors == timeouts_before) begin
		read_reg(gb_map_pkg::addr_tima, rd_val);
		diff = rd_val - tma_val;               // counts since reload
		check_count++;
		if (diff > 8'd2) begin
			value_errors++;
			$display("error timer reload: expected %02h to %02h, actual %02h",
				tma_val, tma_val + 8'd2, rd_val);
		end
	end
	// DIV has to be nonzero before the clear
	wait_reg_bit(gb_map_pkg::addr_div, 0, 400, "divider count");
	bus_write(gb_map_pkg::addr_div, rand_byte());
	read_reg(gb_map_pkg::addr_div, rd_val);
	check_byte("div after write", 8'h00, rd_val);
	bus_write(gb_map_pkg::addr_tac, 8'h00);
	bus_write(gb_map_pkg::addr_if, 8'h00);
endtask

task automatic test_joypad();
	gb_types_pkg::byte_t pressed;
	gb_types_pkg::byte_t rd_val;
	logic [1:0]          p54;
	logic [3:0]          nibble;
	pressed = rand_byte();
	@(posedge clk_cpu);
	joystick <= pressed;
	for (int s = 0; s < 4; s++) begin
		p54 = 2'(s);
		bus_write(gb_map_pkg::addr_joyp, {2'b00, p54, 4'h0});
		// low select opens its group, pressed pulls low
		nibble = 4'hf;
		if (!p54[0])
			nibble = nibble & ~pressed[3:0];    // directions
		if (!p54[1])
			nibble = nibble & ~pressed[7:4];    // buttons
		read_reg(gb_map_pkg::addr_joyp, rd_val);
		check_byte("joypad read", {2'b11, p54, nibble}, rd_val);
		check_byte("joypad p54", {2'b00, p54, nibble}, {2'b00, joy_p54});
	end
	@(posedge clk_cpu);
	joystick <= 8'h00;
	bus_write(gb_map_pkg::addr_joyp, 8'h00);   // both groups open
	bus_write(gb_map_pkg::addr_if, 8'h00);
	@(posedge clk_cpu);
	joystick <= 8'h10;                         // press a
	wait_reg_bit(gb_map_pkg::addr_if, 4, 20, "joypad press");
	@(posedge clk_cpu);
	joystick <= 8'h00;
	bus_write(gb_map_pkg::addr_joyp, 8'h30);
	bus_write(gb_map_pkg::addr_if, 8'h00);
endtask

task automatic test_speed();
	gb_types_pkg::byte_t rd_val;
	logic                cur;
	@(posedge clk_cpu);
	is_gbc <= 1'b0;
	bus_write(gb_map_pkg::addr_key1, 8'h01);   // ignored in mono
	pulse_stop();
	read_reg(gb_map_pkg::addr_key1, rd_val);
	check_byte("key1 mono", 8'h7e, rd_val);
	check_bit("speed mono", 1'b0, speed);
	@(posedge clk_cpu);
	is_gbc <= 1'b1;
	cur = 1'b0;
	for (int round = 0; round < 2; round++) begin
		bus_write(gb_map_pkg::addr_key1, 8'h01);
		read_reg(gb_map_pkg::addr_key1, rd_val);
		check_byte("key1 armed", {cur, 6'h3f, 1'b1}, rd_val);
		pulse_stop();
		read_reg(gb_map_pkg::addr_key1, rd_val);
		check_byte("key1 after stop", {~cur, 6'h3f, 1'b0}, rd_val);  // disarmed
		check_bit("speed after stop", ~cur, speed);
		cur = ~cur;
	end
endtask

task automatic test_unmapped();
	gb_types_pkg::cpu_addr_t addrs [0:7];
	gb_types_pkg::byte_t     rd_val;
	addrs = '{16'h0000, 16'h4abc, 16'h8000, 16'ha000, 16'hfe00, 16'hff01, 16'hff10, 16'hff7f};
	foreach (addrs[i]) begin
		read_reg(addrs[i], rd_val);
		check_byte("unmapped read", 8'hff, rd_val);
	end
endtask

`endif

/* tb_gb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gb_core;

	logic                   clk_cpu;
	logic                   reset;
	gb_types_pkg::cpu_bus_t bus;
	logic                   irq_ack;
	logic                   stop;
	logic                   is_gbc;
	gb_types_pkg::byte_t    joystick;   // active high buttons
	gb_types_pkg::byte_t    rdata;
	logic                   irq_n;
	logic                   speed;
	logic [5:0]             joy_p54;

	logic [31:0] lfsr_state;
	int          check_count;
	int          value_errors;
	int          timeout_errors;

	`include "tb_gb_tasks.svh"

	gb_core dut0 (
		.clk_cpu(clk_cpu), .reset(reset), .bus(bus), .irq_ack(irq_ack), .stop(stop),
		.is_gbc(is_gbc), .joystick(joystick), .rdata(rdata), .irq_n(irq_n),
		.speed(speed), .joy_p54(joy_p54)
	);

	// 20 ns clock
	initial begin
		clk_cpu = 1'b0;
		forever #10 clk_cpu = ~clk_cpu;
	end

	// -------------------------------------------------------------------
	// test sequence
	// -------------------------------------------------------------------
	initial begin
		reset          = 1'b1;
		bus            = make_bus(16'h0000, 8'h00, 1'b0, 1'b0);  // idle, unmapped
		irq_ack        = 1'b0;
		stop           = 1'b0;
		is_gbc         = 1'b0;
		joystick       = 8'h00;
		lfsr_state     = 32'h1ff2_aa3c;
		check_count    = 0;
		value_errors   = 0;
		timeout_errors = 0;
		repeat (2) @(posedge clk_cpu);
		reset <= 1'b0;
		check_reset_values();
		test_ram_banking();
		test_irq_priority();
		test_timer();
		test_joypad();
		test_speed();
		test_unmapped();
		$display("checks %0d, value errors %0d, timeouts %0d",
			check_count, value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
gb_map_pkg.sv
gb_types_pkg.sv
gb_bus_decode.sv
gb_irq_ctrl.sv
gb_timer.sv
gb_speed_fsm.sv
gb_joypad.sv
gb_work_ram.sv
gb_core.sv
+incdir+.
tb_gb_core.sv

/* run.sh */
#!/bin/bash
# build the testbench with Verilator, run it, then judge the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_gb_core -f list.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| echo "build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q "^Verification passed$" sim.log && exit 0 || exit 1
